// File: Makefile
# Verilator build and run for the ingress aggregator

VERILATOR  ?= verilator
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
TOP        := ingress_tb
FILELIST   := list.f
OBJ_DIR    := obj_dir
PASS_MSG   := TEST OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only when the simulation prints the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: hdl/ingress_params.svh
// Ingress aggregator sizes

`ifndef INGRESS_PARAMS_SVH
`define INGRESS_PARAMS_SVH

// Number of narrow ingress ports
`define ING_NUM_PORTS       4

// Bytes per ingress beat and per egress word
`define ING_PORT_BYTES      2
`define ING_BUS_BYTES       8
`define ING_BEATS_PER_WORD  (`ING_BUS_BYTES / `ING_PORT_BYTES)

// Largest legal packet
`define ING_MTU_BYTES       64
`define ING_MTU_WORDS       ((`ING_MTU_BYTES + `ING_BUS_BYTES - 1) / `ING_BUS_BYTES)

// Words per port buffer, room for two full packets at a power of two.
// A packet has to be complete before it leaves, so one MTU alone would
// stall the next packet behind it
`define ING_BUF_DEPTH       (2 ** $clog2(2 * `ING_MTU_WORDS))

`endif

// File: hdl/ingress_pkg.sv
// Ingress aggregator types

`include "ingress_params.svh"

package ingress_pkg;

    // One ingress beat and its byte enables
    typedef logic [8*`ING_PORT_BYTES-1:0] port_data_t;
    typedef logic [`ING_PORT_BYTES-1:0]   port_keep_t;

    // One egress word and its byte enables
    typedef logic [8*`ING_BUS_BYTES-1:0]  bus_data_t;
    typedef logic [`ING_BUS_BYTES-1:0]    bus_keep_t;

    // Source port tag carried with every egress word
    typedef logic [$clog2(`ING_NUM_PORTS)-1:0] port_idx_t;

    // Buffer addressing, the pointer has one extra wrap bit
    typedef logic [$clog2(`ING_BUF_DEPTH)-1:0] buf_addr_t;
    typedef logic [$clog2(`ING_BUF_DEPTH):0]   buf_ptr_t;

    // Egress packet counter
    typedef logic [31:0] pkt_cnt_t;

    typedef enum logic {
        SCHED_IDLE,
        SCHED_SEND
    } sched_state_t;

endpackage

// File: hdl/ingress_port_buffer.sv
// Per-port packet buffer

`timescale 1ns/10ps
`include "ingress_params.svh"

module ingress_port_buffer (
    input  logic                   ing_16b_phys_ports,
    input  logic                   rst,
    input  logic                   port_enable,
    input  logic                   wr_valid,
    input  ingress_pkg::bus_data_t wr_data,
    input  ingress_pkg::bus_keep_t wr_keep,
    input  logic                   wr_last,
    input  logic                   rd_pop,
    output logic                   pkt_ready,
    output ingress_pkg::bus_data_t rd_data,
    output ingress_pkg::bus_keep_t rd_keep,
    output logic                   rd_last,
    output logic                   buf_overflow
);
    import ingress_pkg::*;

    localparam int AW = $clog2(`ING_BUF_DEPTH);

    bus_data_t mem_data [`ING_BUF_DEPTH];
    bus_keep_t mem_keep [`ING_BUF_DEPTH];
    logic      mem_last [`ING_BUF_DEPTH];

    // Write side fills, commit marks the end of the last whole packet,
    // read side drains toward the scheduler
    buf_ptr_t  wr_ptr;
    buf_ptr_t  cm_ptr;
    buf_ptr_t  rd_ptr;
    buf_addr_t wr_addr;
    buf_addr_t rd_addr;

    logic      in_pkt;
    logic      discard;
    logic      full;
    logic      start_off;
    logic      drop_word;
    logic      wr_en;
    logic      commit;
    logic      retire;
    buf_ptr_t  cmpl_cnt;

    assign wr_addr = wr_ptr[AW-1:0];
    assign rd_addr = rd_ptr[AW-1:0];

    // Full when the pointers meet on different laps
    assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_addr == rd_addr);

    ////////////////////////////////////////
    // Write and drop decisions

    // Enable is looked at only on the first word of a packet
    assign start_off = !in_pkt && !port_enable;
    assign drop_word = discard || start_off || full;
    assign wr_en     = wr_valid && !drop_word;
    assign commit    = wr_en && wr_last;
    assign retire    = rd_pop && rd_last;

    always_ff @(posedge ing_16b_phys_ports) begin
        if (rst) begin
            wr_ptr       <= '0;
            cm_ptr       <= '0;
            in_pkt       <= 1'b0;
            discard      <= 1'b0;
            buf_overflow <= 1'b0;
        end else begin
            if (wr_valid) begin
                in_pkt  <= !wr_last;
                discard <= drop_word && !wr_last;
                if (drop_word) begin
                    // Throw away whatever of this packet was already stored
                    wr_ptr <= cm_ptr;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (commit) begin
                cm_ptr <= wr_ptr + 1'b1;
            end
            if (wr_valid && full && !discard && !start_off) begin
                buf_overflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge ing_16b_phys_ports) begin
        if (wr_en) begin
            mem_data[wr_addr] <= wr_data;
            mem_keep[wr_addr] <= wr_keep;
            mem_last[wr_addr] <= wr_last;
        end
    end

    ////////////////////////////////////////
    // Read side

    assign rd_data = mem_data[rd_addr];
    assign rd_keep = mem_keep[rd_addr];
    assign rd_last = mem_last[rd_addr];

    always_ff @(posedge ing_16b_phys_ports) begin
        if (rst) begin
            rd_ptr   <= '0;
            cmpl_cnt <= '0;
        end else begin
            if (rd_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Number of whole packets waiting
            case ({commit, retire})
                2'b10:   cmpl_cnt <= cmpl_cnt + 1'b1;
                2'b01:   cmpl_cnt <= cmpl_cnt - 1'b1;
                default: cmpl_cnt <= cmpl_cnt;
            endcase
        end
    end

    assign pkt_ready = (cmpl_cnt != '0);

endmodule

// File: hdl/ingress_scheduler.sv
// Round-robin egress scheduler

`timescale 1ns/10ps
`include "ingress_params.svh"

module ingress_scheduler (
    input  logic                     ing_16b_phys_ports,
    input  logic                     rst,
    input  logic [`ING_NUM_PORTS-1:0] pkt_ready,
    input  ingress_pkg::bus_data_t   rd_data [`ING_NUM_PORTS],
    input  ingress_pkg::bus_keep_t   rd_keep [`ING_NUM_PORTS],
    input  logic [`ING_NUM_PORTS-1:0] rd_last,
    input  logic                     out_ready,
    input  logic                     pkt_cnt_clear,
    output logic [`ING_NUM_PORTS-1:0] rd_pop,
    output logic                     out_valid,
    output ingress_pkg::bus_data_t   out_data,
    output ingress_pkg::bus_keep_t   out_keep,
    output logic                     out_last,
    output ingress_pkg::port_idx_t   out_user,
    output ingress_pkg::pkt_cnt_t    pkt_cnt
);
    import ingress_pkg::*;

    sched_state_t state;
    port_idx_t    sel;
    port_idx_t    pick;
    logic         any_ready;
    logic         out_fire;
    int           idx;

    ////////////////////////////////////////
    // Port choice

    // Search starts just after the port served last, so every port with
    // a complete packet gets its turn
    always_comb begin
        any_ready = 1'b0;
        pick      = sel;
        for (int i = 1; i <= `ING_NUM_PORTS; i++) begin
            idx = (int'(sel) + i) % `ING_NUM_PORTS;
            if (!any_ready && pkt_ready[idx]) begin
                any_ready = 1'b1;
                pick      = port_idx_t'(idx);
            end
        end
    end

    always_ff @(posedge ing_16b_phys_ports) begin
        if (rst) begin
            state <= SCHED_IDLE;
            // Port 0 comes first after reset
            sel   <= port_idx_t'(`ING_NUM_PORTS - 1);
        end else begin
            case (state)
                SCHED_IDLE: begin
                    if (any_ready) begin
                        sel   <= pick;
                        state <= SCHED_SEND;
                    end
                end
                SCHED_SEND: begin
                    if (out_fire && out_last) begin
                        state <= SCHED_IDLE;
                    end
                end
                default: state <= SCHED_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////
    // Egress mux

    // The selected buffer holds its head word until popped, which keeps
    // the bus stable under back-pressure
    assign out_valid = (state == SCHED_SEND);
    assign out_data  = rd_data[sel];
    assign out_keep  = rd_keep[sel];
    assign out_last  = rd_last[sel];
    assign out_user  = sel;
    assign out_fire  = out_valid && out_ready;

    always_comb begin
        rd_pop      = '0;
        rd_pop[sel] = out_fire;
    end

    // Egress packets, saturating, clear has priority
    always_ff @(posedge ing_16b_phys_ports) begin
        if (rst || pkt_cnt_clear) begin
            pkt_cnt <= '0;
        end else if (out_fire && out_last && !(&pkt_cnt)) begin
            pkt_cnt <= pkt_cnt + 1'b1;
        end
    end

endmodule

// File: hdl/ingress_top.sv
// Ingress aggregator top level

`timescale 1ns/10ps
`include "ingress_params.svh"

module ingress_top (
    input  logic                      ing_16b_phys_ports,
    input  logic                      rst,
    input  logic [`ING_NUM_PORTS-1:0] in_valid,
    input  ingress_pkg::port_data_t   in_data [`ING_NUM_PORTS],
    input  ingress_pkg::port_keep_t   in_keep [`ING_NUM_PORTS],
    input  logic [`ING_NUM_PORTS-1:0] in_last,
    input  logic [`ING_NUM_PORTS-1:0] port_enable,
    input  logic                      out_ready,
    input  logic                      pkt_cnt_clear,
    output logic                      out_valid,
    output ingress_pkg::bus_data_t    out_data,
    output ingress_pkg::bus_keep_t    out_keep,
    output logic                      out_last,
    output ingress_pkg::port_idx_t    out_user,
    output ingress_pkg::pkt_cnt_t     pkt_cnt,
    output logic [`ING_NUM_PORTS-1:0] buf_overflow
);
    import ingress_pkg::*;

    logic [`ING_NUM_PORTS-1:0] wr_valid;
    bus_data_t                 wr_data [`ING_NUM_PORTS];
    bus_keep_t                 wr_keep [`ING_NUM_PORTS];
    logic [`ING_NUM_PORTS-1:0] wr_last;
    logic [`ING_NUM_PORTS-1:0] pkt_ready;
    bus_data_t                 rd_data [`ING_NUM_PORTS];
    bus_keep_t                 rd_keep [`ING_NUM_PORTS];
    logic [`ING_NUM_PORTS-1:0] rd_last;
    logic [`ING_NUM_PORTS-1:0] rd_pop;

    ////////////////////////////////////////
    // Per-port adapter and buffer

    for (genvar p = 0; p < `ING_NUM_PORTS; p++) begin : gen_port
        ingress_width_adapt u_adapt (
            .ing_16b_phys_ports ( ing_16b_phys_ports ),
            .rst                ( rst                ),
            .in_valid           ( in_valid[p]        ),
            .in_data            ( in_data[p]         ),
            .in_keep            ( in_keep[p]         ),
            .in_last            ( in_last[p]         ),
            .wr_valid           ( wr_valid[p]        ),
            .wr_data            ( wr_data[p]         ),
            .wr_keep            ( wr_keep[p]         ),
            .wr_last            ( wr_last[p]         )
        );

        ingress_port_buffer u_buf (
            .ing_16b_phys_ports ( ing_16b_phys_ports ),
            .rst                ( rst                ),
            .port_enable        ( port_enable[p]     ),
            .wr_valid           ( wr_valid[p]        ),
            .wr_data            ( wr_data[p]         ),
            .wr_keep            ( wr_keep[p]         ),
            .wr_last            ( wr_last[p]         ),
            .rd_pop             ( rd_pop[p]          ),
            .pkt_ready          ( pkt_ready[p]       ),
            .rd_data            ( rd_data[p]         ),
            .rd_keep            ( rd_keep[p]         ),
            .rd_last            ( rd_last[p]         ),
            .buf_overflow       ( buf_overflow[p]    )
        );
    end

    ////////////////////////////////////////
    // Merge onto the egress bus

    ingress_scheduler u_sched (
        .ing_16b_phys_ports ( ing_16b_phys_ports ),
        .rst                ( rst                ),
        .pkt_ready          ( pkt_ready          ),
        .rd_data            ( rd_data            ),
        .rd_keep            ( rd_keep            ),
        .rd_last            ( rd_last            ),
        .out_ready          ( out_ready          ),
        .pkt_cnt_clear      ( pkt_cnt_clear      ),
        .rd_pop             ( rd_pop             ),
        .out_valid          ( out_valid          ),
        .out_data           ( out_data           ),
        .out_keep           ( out_keep           ),
        .out_last           ( out_last           ),
        .out_user           ( out_user           ),
        .pkt_cnt            ( pkt_cnt            )
    );

endmodule

// File: hdl/ingress_width_adapt.sv
// Ingress width adapter

`timescale 1ns/10ps
`include "ingress_params.svh"

module ingress_width_adapt (
    input  logic                    ing_16b_phys_ports,
    input  logic                    rst,
    input  logic                    in_valid,
    input  ingress_pkg::port_data_t in_data,
    input  ingress_pkg::port_keep_t in_keep,
    input  logic                    in_last,
    output logic                    wr_valid,
    output ingress_pkg::bus_data_t  wr_data,
    output ingress_pkg::bus_keep_t  wr_keep,
    output logic                    wr_last
);
    import ingress_pkg::*;

    localparam int LANE_W    = $clog2(`ING_BEATS_PER_WORD);
    localparam int BEAT_BITS = 8 * `ING_PORT_BYTES;
    localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(`ING_BEATS_PER_WORD - 1);

    logic [LANE_W-1:0] lane;
    bus_data_t         acc_data;
    bus_keep_t         acc_keep;
    bus_data_t         nxt_data;
    bus_keep_t         nxt_keep;
    logic              word_done;

    ////////////////////////////////////////
    // Lane packing

    // The incoming beat merged into the word under construction
    always_comb begin
        nxt_data = acc_data;
        nxt_keep = acc_keep;
        nxt_data[lane*BEAT_BITS +: BEAT_BITS] = in_data;
        nxt_keep[lane*`ING_PORT_BYTES +: `ING_PORT_BYTES] = in_keep;
    end

    // A word closes on its top lane or on the end of a packet
    assign word_done = in_valid && (in_last || lane == LAST_LANE);

    always_ff @(posedge ing_16b_phys_ports) begin
        if (rst) begin
            lane     <= '0;
            acc_keep <= '0;
            wr_valid <= 1'b0;
        end else begin
            wr_valid <= word_done;
            if (word_done) begin
                // Next packet or next word starts again in lane 0
                lane     <= '0;
                acc_keep <= '0;
            end else if (in_valid) begin
                lane     <= lane + 1'b1;
                acc_keep <= nxt_keep;
            end
        end
    end

    ////////////////////////////////////////
    // Word output

    always_ff @(posedge ing_16b_phys_ports) begin
        if (in_valid) begin
            acc_data <= nxt_data;
        end
        if (word_done) begin
            wr_data <= nxt_data;
            wr_keep <= nxt_keep;
            wr_last <= in_last;
        end
    end

endmodule

// File: list.f
+incdir+hdl
hdl/ingress_pkg.sv
hdl/ingress_width_adapt.sv
hdl/ingress_port_buffer.sv
hdl/ingress_scheduler.sv
hdl/ingress_top.sv
test/ingress_checker.sv
test/ingress_tb.sv

// File: test/ingress_checker.sv
// Egress protocol checker

`timescale 1ns/10ps
`include "ingress_params.svh"

module ingress_checker (
    input logic                      ing_16b_phys_ports,
    input logic                      rst,
    input logic                      out_valid,
    input logic                      out_ready,
    input ingress_pkg::bus_data_t    out_data,
    input ingress_pkg::bus_keep_t    out_keep,
    input logic                      out_last,
    input ingress_pkg::port_idx_t    out_user,
    input ingress_pkg::pkt_cnt_t     pkt_cnt,
    input logic                      pkt_cnt_clear,
    input logic [`ING_NUM_PORTS-1:0] buf_overflow
);

    int fail_cnt = 0;

    ////////////////////////////////////////
    // Egress bus

    // A stalled word stays exactly as it was offered
    a_hold_on_stall: assert property (
        @(posedge ing_16b_phys_ports) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_keep)
            && $stable(out_last) && $stable(out_user)
    ) else begin
        fail_cnt++;
        $error("Egress word changed or vanished while out_ready was low");
    end

    // Words of one packet are never split by another port
    a_no_interleave: assert property (
        @(posedge ing_16b_phys_ports) disable iff (rst)
        out_valid && out_ready && !out_last |=> $stable(out_user)
    ) else begin
        fail_cnt++;
        $error("out_user changed inside a packet");
    end

    ////////////////////////////////////////
    // Counter and flags

    a_cnt_clear: assert property (
        @(posedge ing_16b_phys_ports) disable iff (rst)
        pkt_cnt_clear |=> pkt_cnt == '0
    ) else begin
        fail_cnt++;
        $error("pkt_cnt not zero one cycle after pkt_cnt_clear");
    end

    // Every overflow bit once set stays set until reset
    a_overflow_sticky: assert property (
        @(posedge ing_16b_phys_ports) disable iff (rst)
        |buf_overflow |=> &(buf_overflow | ~$past(buf_overflow))
    ) else begin
        fail_cnt++;
        $error("A buf_overflow bit fell without a reset");
    end

endmodule

bind ingress_top ingress_checker u_chk (.*);

// File: test/ingress_tb.sv
// Ingress aggregator testbench

`timescale 1ns/10ps
`include "ingress_params.svh"

module ingress_tb;
    import ingress_pkg::*;

    localparam int READY_LOW   = 0;
    localparam int READY_RAND  = 1;
    localparam int DRAIN_LIMIT = 3000;

    logic                      ing_16b_phys_ports = 1'b0;
    logic                      rst;
    logic [`ING_NUM_PORTS-1:0] in_valid;
    port_data_t                in_data [`ING_NUM_PORTS];
    port_keep_t                in_keep [`ING_NUM_PORTS];
    logic [`ING_NUM_PORTS-1:0] in_last;
    logic [`ING_NUM_PORTS-1:0] port_enable;
    logic                      out_ready = 1'b0;
    logic                      pkt_cnt_clear;
    logic                      out_valid;
    bus_data_t                 out_data;
    bus_keep_t                 out_keep;
    logic                      out_last;
    port_idx_t                 out_user;
    pkt_cnt_t                  pkt_cnt;
    logic [`ING_NUM_PORTS-1:0] buf_overflow;

    logic [31:0] lfsr_state = 32'h69c1_7b6d;
    int          ready_mode = READY_LOW;
    // Bytes and packet lengths still owed by each port
    logic [7:0]  byte_q [`ING_NUM_PORTS][$];
    int          len_q [`ING_NUM_PORTS][$];
    int          remain [`ING_NUM_PORTS] = '{default: 0};
    int          exp_cnt = 0;
    int          data_errs = 0;
    int          timeouts = 0;

    ingress_top uut (.*);

    always #4 ing_16b_phys_ports = ~ing_16b_phys_ports;

    ////////////////////////////////////////
    // Random source

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    // Egress is ready seven cycles in eight in random mode
    always @(posedge ing_16b_phys_ports) begin
        #1;
        if (ready_mode == READY_RAND) begin
            out_ready = (rand_bits(3) != 0);
        end else begin
            out_ready = 1'b0;
        end
    end

    ////////////////////////////////////////
    // Stimulus

    task automatic send_packet(input int p, input int len, input bit expect_out);
        logic [7:0] pkt [$];
        for (int i = 0; i < len; i++) begin
            pkt.push_back(8'(rand_bits(8)));
        end
        if (expect_out) begin
            for (int i = 0; i < len; i++) begin
                byte_q[p].push_back(pkt[i]);
            end
            len_q[p].push_back(len);
        end
        // First byte of the packet rides in the low byte of the beat
        for (int i = 0; i < len; i += 2) begin
            @(posedge ing_16b_phys_ports);
            #1;
            in_valid[p] = 1'b1;
            in_data[p]  = {((i + 1 < len) ? pkt[i + 1] : 8'h00), pkt[i]};
            in_keep[p]  = (i + 1 < len) ? 2'b11 : 2'b01;
            in_last[p]  = (i + 2 >= len);
        end
        @(posedge ing_16b_phys_ports);
        #1;
        in_valid[p] = 1'b0;
        in_last[p]  = 1'b0;
    endtask

    task automatic port_traffic(input int p, input int npkt);
        int gap;
        int len;
        repeat (npkt) begin
            gap = 4 + int'(rand_bits(5));
            len = 1 + int'(rand_bits(5));
            repeat (gap) @(posedge ing_16b_phys_ports);
            send_packet(p, len, 1'b1);
        end
    endtask

    task automatic pulse_clear(input int delay_cycles);
        repeat (delay_cycles) @(posedge ing_16b_phys_ports);
        #1;
        pkt_cnt_clear = 1'b1;
        @(posedge ing_16b_phys_ports);
        #1;
        pkt_cnt_clear = 1'b0;
    endtask

    function automatic bit all_drained();
        bit done;
        done = 1'b1;
        for (int p = 0; p < `ING_NUM_PORTS; p++) begin
            if (len_q[p].size() != 0 || remain[p] != 0) begin
                done = 1'b0;
            end
        end
        return done;
    endfunction

    task automatic wait_drain(input int limit);
        int t;
        t = 0;
        while (!all_drained() && t < limit) begin
            @(posedge ing_16b_phys_ports);
            t++;
        end
        if (!all_drained()) begin
            timeouts++;
            $display("Timeout after %0d cycles waiting for expected packets on egress", limit);
        end
    endtask

    ////////////////////////////////////////
    // Egress monitor

    task automatic check_word();
        int         p;
        int         n;
        bus_keep_t  exp_keep;
        logic [7:0] exp_byte;
        p = int'(out_user);
        if (remain[p] == 0 && len_q[p].size() == 0) begin
            data_errs++;
            $display("Port %0d sent a word at %0t with no packet outstanding", p, $time);
        end else begin
            if (remain[p] == 0) begin
                remain[p] = len_q[p].pop_front();
            end
            n = (remain[p] < `ING_BUS_BYTES) ? remain[p] : `ING_BUS_BYTES;
            exp_keep = bus_keep_t'((1 << n) - 1);
            assert (out_keep == exp_keep) else begin
                data_errs++;
                $display("mismatch at %0t: out_keep got %h expected %h", $time, out_keep, exp_keep);
            end
            assert (out_last == (remain[p] <= `ING_BUS_BYTES)) else begin
                data_errs++;
                $display("mismatch at %0t: out_last got %b expected %b", $time, out_last,
                         remain[p] <= `ING_BUS_BYTES);
            end
            for (int b = 0; b < n; b++) begin
                exp_byte = byte_q[p].pop_front();
                assert (out_data[8*b +: 8] == exp_byte) else begin
                    data_errs++;
                    $display("mismatch at %0t: out_data byte %0d port %0d got %h expected %h",
                             $time, b, p, out_data[8*b +: 8], exp_byte);
                end
            end
            remain[p] -= n;
        end
    endtask

    // Inputs move 1 ns after the rising edge, so the falling edge sees a settled cycle
    always @(negedge ing_16b_phys_ports) begin
        if (!rst) begin
            assert (pkt_cnt == pkt_cnt_t'(exp_cnt)) else begin
                data_errs++;
                $display("mismatch at %0t: pkt_cnt got %0d expected %0d", $time, pkt_cnt, exp_cnt);
            end
            if (out_valid && out_ready) begin
                check_word();
            end
            if (pkt_cnt_clear) begin
                exp_cnt = 0;
            end else if (out_valid && out_ready && out_last) begin
                exp_cnt++;
            end
        end
    end

    ////////////////////////////////////////
    // Test sequence

    initial begin
        rst           = 1'b1;
        in_valid      = '0;
        in_last       = '0;
        port_enable   = '1;
        pkt_cnt_clear = 1'b0;
        for (int p = 0; p < `ING_NUM_PORTS; p++) begin
            in_data[p] = '0;
            in_keep[p] = '0;
        end
        repeat (10) @(posedge ing_16b_phys_ports);
        #1;
        rst        = 1'b0;
        ready_mode = READY_RAND;

        // All ports at once under random back-pressure with a counter clear mid-run
        fork
            port_traffic(0, 12);
            port_traffic(1, 12);
            port_traffic(2, 12);
            port_traffic(3, 12);
            pulse_clear(200);
        join
        wait_drain(DRAIN_LIMIT);
        assert (buf_overflow == '0) else begin
            data_errs++;
            $display("mismatch at %0t: buf_overflow got %b expected 0", $time, buf_overflow);
        end

        // Port 1 disabled for a whole packet, then enabled in the middle of one
        @(posedge ing_16b_phys_ports);
        #1;
        port_enable[1] = 1'b0;
        send_packet(1, 10, 1'b0);
        fork
            send_packet(1, 40, 1'b0);
            begin
                repeat (10) @(posedge ing_16b_phys_ports);
                #1;
                port_enable[1] = 1'b1;
            end
        join
        send_packet(1, 24, 1'b1);
        wait_drain(DRAIN_LIMIT);

        // Port 0 overflows behind a stalled egress and loses its third packet
        @(posedge ing_16b_phys_ports);
        #1;
        ready_mode = READY_LOW;
        send_packet(0, 16, 1'b1);
        send_packet(0, `ING_MTU_BYTES, 1'b1);
        send_packet(0, `ING_MTU_BYTES, 1'b0);
        assert (buf_overflow[0]) else begin
            data_errs++;
            $display("mismatch at %0t: buf_overflow[0] got 0 expected 1", $time);
        end
        ready_mode = READY_RAND;
        wait_drain(DRAIN_LIMIT);
        send_packet(0, 20, 1'b1);
        wait_drain(DRAIN_LIMIT);
        assert (buf_overflow == `ING_NUM_PORTS'(1)) else begin
            data_errs++;
            $display("mismatch at %0t: buf_overflow got %b expected 0001", $time, buf_overflow);
        end

        pulse_clear(2);
        repeat (4) @(posedge ing_16b_phys_ports);

        $display("Errors: %0d data, %0d timeout, %0d assertion",
                 data_errs, timeouts, uut.u_chk.fail_cnt);
        if (data_errs == 0 && timeouts == 0 && uut.u_chk.fail_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
